/* logic/dkp_pkg.sv */
// shared modes, geometry and field widths of the disk controller, used by scoped names
package dkp_pkg;

    // command mode in A[9:8]
    typedef enum logic [1:0] {
        MODE_READ  = 2'd0,
        MODE_WRITE = 2'd1,
        MODE_SEEK  = 2'd2,
        MODE_RECAL = 2'd3
    } mode_e;

    localparam int CYL_W          = 8;
    localparam int SURF_W         = 4;
    localparam int SECT_W         = 3;
    localparam int CNT_W          = 5;   // count runs up to 16
    localparam int WIDX_W         = 9;   // word index, up to 256

    localparam int SECTS_PER_SURF = 6;
    localparam int SURSEC_W       = 6;   // surf * 6 + sect

    // cylinder | surf*6+sect | word | byte select
    localparam int FLS_ADDR_W     = CYL_W + SURSEC_W + (WIDX_W - 1) + 1;

    localparam logic [7:0] SPI_READ_OP = 8'h03;

    localparam int WORD_W         = 16;
    localparam int MADDR_W        = 15;

endpackage

/* logic/dkp_regs.sv */
// host command registers A/B/C, busy/done flags and the status word mux
module dkp_regs (
    input  logic                        i_DRA,
    input  logic                        i_dev_ZZ0,
    input  logic [dkp_pkg::WORD_W-1:0]  i_dev_sr,
    input  logic                        i_load_a,
    input  logic                        i_load_b,
    input  logic                        i_load_c,
    input  logic                        i_start,
    input  logic                        i_clear,
    input  logic                        i_cmd_done,
    input  logic [1:0]                  i_stat_sel,
    input  logic                        i_rw_done,
    input  logic                        i_seek_done,
    input  logic [dkp_pkg::MADDR_W-1:0] i_maddr,
    input  logic [dkp_pkg::SURF_W-1:0]  i_surf,
    input  logic [dkp_pkg::SECT_W-1:0]  i_sect,
    input  logic [3:0]                  i_count,
    output dkp_pkg::mode_e              o_mode,
    output logic [dkp_pkg::CYL_W-1:0]   o_cyl_arg,
    output logic [dkp_pkg::WORD_W-1:0]  o_b,
    output logic [dkp_pkg::WORD_W-1:0]  o_c,
    output logic                        o_busy,
    output logic                        o_done,
    output logic [dkp_pkg::WORD_W-1:0]  o_dev_sc
);

    logic [dkp_pkg::WORD_W-1:0] a_q;

    assign o_mode    = dkp_pkg::mode_e'(a_q[9:8]);
    assign o_cyl_arg = a_q[dkp_pkg::CYL_W-1:0];

    always_ff @(posedge i_DRA or posedge i_dev_ZZ0) begin
        if (i_dev_ZZ0) begin
            a_q    <= '0;
            o_b    <= '0;
            o_c    <= '0;
            o_busy <= 1'b0;
            o_done <= 1'b0;
        end else begin
            if (i_load_a) a_q <= i_dev_sr;
            if (i_load_b) o_b <= i_dev_sr;
            if (i_load_c) o_c <= i_dev_sr;

            if (i_start) begin
                o_busy <= 1'b1;
                o_done <= 1'b0;
            end else if (i_clear) begin
                o_busy <= 1'b0;
                o_done <= 1'b0;
            end else if (i_cmd_done) begin   // command finished in the FSM
                o_busy <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end

    always_comb begin
        case (i_stat_sel)
            2'd0:    o_dev_sc = {i_rw_done, i_seek_done, 14'd0};
            2'd1:    o_dev_sc = {1'b0, i_maddr};
            2'd2:    o_dev_sc = {4'd0, i_surf, 1'b0, i_sect, i_count};
            default: o_dev_sc = '0;
        endcase
    end

    a_busy_done_excl: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        !(o_busy && o_done))
        else $error("busy and done high together");

endmodule

/* logic/dkp_geometry.sv */
// disk position counters; forms the flash byte address of the current word
module dkp_geometry #(
    parameter int SECTOR_WORDS = 256
) (
    input  logic                           i_DRA,
    input  logic                           i_dev_ZZ0,
    input  logic [dkp_pkg::WORD_W-1:0]     i_c,
    input  logic                           i_load,
    input  logic                           i_cyl_load,
    input  logic                           i_cyl_clear,
    input  logic [dkp_pkg::CYL_W-1:0]      i_cyl_arg,
    input  logic                           i_word_step,
    input  logic                           i_sector_step,
    input  logic                           i_byte_sel,
    output logic [dkp_pkg::FLS_ADDR_W-1:0] o_flash_addr,
    output logic [dkp_pkg::SURF_W-1:0]     o_surf,
    output logic [dkp_pkg::SECT_W-1:0]     o_sect,
    output logic [3:0]                     o_count,
    output logic                           o_sector_end,
    output logic                           o_last_sector
);

    logic [dkp_pkg::CYL_W-1:0]    cyl;
    logic [dkp_pkg::CNT_W-1:0]    count;
    logic [dkp_pkg::WIDX_W-1:0]   widx;
    logic [dkp_pkg::SURSEC_W-1:0] sursec;

    assign sursec = dkp_pkg::SURSEC_W'(o_surf) * dkp_pkg::SURSEC_W'(dkp_pkg::SECTS_PER_SURF)
                  + dkp_pkg::SURSEC_W'(o_sect);

    assign o_flash_addr  = {cyl, sursec, widx[dkp_pkg::WIDX_W-2:0], i_byte_sel};
    assign o_count       = count[3:0];
    assign o_sector_end  = (widx == dkp_pkg::WIDX_W'(SECTOR_WORDS));
    assign o_last_sector = (count == dkp_pkg::CNT_W'(16));   // count wrapped past 15

    always_ff @(posedge i_DRA or posedge i_dev_ZZ0) begin
        if (i_dev_ZZ0) begin
            cyl    <= '0;
            o_surf <= '0;
            o_sect <= '0;
            count  <= '0;
            widx   <= '0;
        end else begin
            if (i_cyl_clear)
                cyl <= '0;
            else if (i_cyl_load)
                cyl <= i_cyl_arg;

            if (i_load) begin
                o_surf <= i_c[11:8];
                o_sect <= i_c[6:4];
                count  <= {1'b0, i_c[3:0]};
                widx   <= '0;
            end else if (i_sector_step) begin
                count <= count + 1'b1;
                widx  <= '0;
                if (o_sect == dkp_pkg::SECT_W'(dkp_pkg::SECTS_PER_SURF - 1)) begin
                    o_sect <= '0;              // next surface
                    o_surf <= o_surf + 1'b1;
                end else begin
                    o_sect <= o_sect + 1'b1;
                end
            end else if (i_word_step) begin
                widx <= widx + 1'b1;
            end
        end
    end

endmodule

/* logic/dkp_spi_reader.sv */
// SPI mode-0 master that reads one byte from the flash at a given address
module dkp_spi_reader (
    input  logic                           i_DRA,
    input  logic                           i_dev_ZZ0,
    input  logic                           i_start,
    input  logic [dkp_pkg::FLS_ADDR_W-1:0] i_addr,
    input  logic                           i_spi_miso,
    output logic                           o_spi_sck,
    output logic                           o_spi_ncs,
    output logic                           o_spi_mosi,
    output logic                           o_busy,
    output logic                           o_byte_valid,
    output logic [7:0]                     o_byte
);

    // 40 sck periods of 2 clocks each, then ncs release and done
    localparam logic [6:0] PH_LAST_SCK = 7'd80;
    localparam logic [6:0] PH_RX_FIRST = 7'd64;  // first data bit, after op + addr
    localparam logic [6:0] PH_DONE     = 7'd81;

    logic [6:0]  ph;
    logic [31:0] tx;
    logic [7:0]  rx;

    assign o_spi_mosi = tx[31];
    assign o_byte     = rx;

    always_ff @(posedge i_DRA or posedge i_dev_ZZ0) begin
        if (i_dev_ZZ0) begin
            ph           <= '0;
            o_busy       <= 1'b0;
            o_spi_ncs    <= 1'b1;
            o_spi_sck    <= 1'b0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            if (i_start) begin
                ph        <= '0;
                o_busy    <= 1'b1;
                o_spi_ncs <= 1'b0;
            end else if (o_busy) begin
                ph <= ph + 7'd1;
                if (ph < PH_LAST_SCK)
                    o_spi_sck <= ~ph[0];   // even phase rises, odd falls
                if (ph == PH_LAST_SCK)
                    o_spi_ncs <= 1'b1;
                if (ph == PH_DONE) begin
                    o_busy       <= 1'b0;
                    o_byte_valid <= 1'b1;
                end
            end
        end
    end

    // shifters
    always_ff @(posedge i_DRA) begin
        if (i_start)
            tx <= {dkp_pkg::SPI_READ_OP, {(24 - dkp_pkg::FLS_ADDR_W){1'b0}}, i_addr};
        else if (o_busy && ph[0] && ph < PH_LAST_SCK)
            tx <= {tx[30:0], 1'b0};   // after falling sck

        if (o_busy && !ph[0] && ph >= PH_RX_FIRST && ph < PH_LAST_SCK)
            rx <= {rx[6:0], i_spi_miso};   // sample on rising sck
    end

    a_no_start_busy: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        i_start |-> !o_busy)
        else $error("spi start while busy");

endmodule

/* logic/dkp_word_out.sv */
// word assembly, credit counting and the word output port with its memory address
module dkp_word_out #(
    parameter int CREDITS = 4
) (
    input  logic                        i_DRA,
    input  logic                        i_dev_ZZ0,
    input  logic                        i_lo_byte,
    input  logic                        i_hi_byte,
    input  logic [7:0]                  i_byte,
    input  logic                        i_send,
    input  logic [dkp_pkg::WORD_W-1:0]  i_b,
    input  logic                        i_load,
    input  logic                        i_credit,
    output logic                        o_sent,
    output logic                        o_word_valid,
    output logic [dkp_pkg::WORD_W-1:0]  o_word,
    output logic [dkp_pkg::MADDR_W-1:0] o_word_addr
);

    localparam int CRED_W = $clog2(CREDITS + 1) + 4;   // headroom for early returns

    logic [CRED_W-1:0] credits;
    logic              pending;

    assign o_sent = o_word_valid;

    always_ff @(posedge i_DRA or posedge i_dev_ZZ0) begin
        if (i_dev_ZZ0) begin
            credits      <= CRED_W'(CREDITS);
            pending      <= 1'b0;
            o_word_valid <= 1'b0;
            o_word_addr  <= '0;
        end else begin
            o_word_valid <= 1'b0;
            credits      <= credits + CRED_W'(i_credit) - CRED_W'(o_word_valid);

            if (i_send)
                pending <= 1'b1;
            else if (pending && credits != '0 && !o_word_valid) begin
                pending      <= 1'b0;
                o_word_valid <= 1'b1;
            end

            if (i_load)
                o_word_addr <= i_b[dkp_pkg::MADDR_W-1:0];
            else if (o_word_valid)
                o_word_addr <= o_word_addr + 1'b1;   // next memory word
        end
    end

    always_ff @(posedge i_DRA) begin
        if (i_lo_byte) o_word[7:0]  <= i_byte;
        if (i_hi_byte) o_word[15:8] <= i_byte;
    end

    a_valid_credit: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        o_word_valid |-> credits != '0)
        else $error("word sent without credit");

endmodule

/* logic/dkp_seq.sv */
// control FSM sequencing seek, recalibrate and multi-sector read
module dkp_seq (
    input  logic           i_DRA,
    input  logic           i_dev_ZZ0,
    input  logic           i_busy,
    input  dkp_pkg::mode_e i_mode,
    input  logic           i_spi_busy,
    input  logic           i_byte_valid,
    input  logic           i_sector_end,
    input  logic           i_last_sector,
    input  logic           i_sent,
    output logic           o_load,
    output logic           o_cyl_load,
    output logic           o_cyl_clear,
    output logic           o_spi_start,
    output logic           o_byte_sel,
    output logic           o_lo_byte,
    output logic           o_hi_byte,
    output logic           o_send,
    output logic           o_word_step,
    output logic           o_sector_step,
    output logic           o_cmd_done,
    output logic           o_rw_done,
    output logic           o_seek_done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_RD_LO,
        S_WAIT_LO,
        S_RD_HI,
        S_WAIT_HI,
        S_SEND,
        S_WAIT_SENT,
        S_NEXT,
        S_CHECK
    } state_t;

    state_t state;
    state_t state_nx;
    logic   in_start;
    logic   read_end;

    assign in_start = (state == S_START);
    assign read_end = (state == S_CHECK) && i_last_sector;

    assign o_load        = in_start && i_mode == dkp_pkg::MODE_READ;
    assign o_cyl_load    = in_start && i_mode == dkp_pkg::MODE_SEEK;
    assign o_cyl_clear   = in_start && i_mode == dkp_pkg::MODE_RECAL;
    assign o_cmd_done    = (in_start && i_mode != dkp_pkg::MODE_READ) || read_end;
    assign o_spi_start   = (state == S_RD_LO || state == S_RD_HI) && !i_spi_busy;
    assign o_byte_sel    = (state == S_RD_HI);
    assign o_lo_byte     = (state == S_WAIT_LO) && i_byte_valid;
    assign o_hi_byte     = (state == S_WAIT_HI) && i_byte_valid;
    assign o_send        = (state == S_SEND);
    assign o_word_step   = (state == S_WAIT_SENT) && i_sent;
    assign o_sector_step = (state == S_NEXT) && i_sector_end;

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE:      if (i_busy) state_nx = S_START;
            S_START:     state_nx = (i_mode == dkp_pkg::MODE_READ) ? S_RD_LO : S_IDLE;
            S_RD_LO:     if (!i_spi_busy) state_nx = S_WAIT_LO;
            S_WAIT_LO:   if (i_byte_valid) state_nx = S_RD_HI;
            S_RD_HI:     if (!i_spi_busy) state_nx = S_WAIT_HI;
            S_WAIT_HI:   if (i_byte_valid) state_nx = S_SEND;
            S_SEND:      state_nx = S_WAIT_SENT;
            S_WAIT_SENT: if (i_sent) state_nx = S_NEXT;   // held here under back-pressure
            S_NEXT:      state_nx = i_sector_end ? S_CHECK : S_RD_LO;
            S_CHECK:     state_nx = i_last_sector ? S_IDLE : S_RD_LO;
            default:     state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge i_DRA or posedge i_dev_ZZ0) begin
        if (i_dev_ZZ0) begin
            state       <= S_IDLE;
            o_rw_done   <= 1'b0;
            o_seek_done <= 1'b0;
        end else begin
            state <= state_nx;
            if (in_start) begin
                case (i_mode)
                    dkp_pkg::MODE_READ:  o_rw_done <= 1'b0;
                    dkp_pkg::MODE_WRITE: o_rw_done <= 1'b1;   // no transfer
                    default:             o_seek_done <= 1'b1;
                endcase
            end
            if (read_end)
                o_rw_done <= 1'b1;
        end
    end

endmodule

/* logic/dkp_top.sv */
// disk controller top level, connects registers, FSM and datapath blocks
module dkp_top #(
    parameter int SECTOR_WORDS = 256,
    parameter int CREDITS      = 4
) (
    input  logic                        i_DRA,
    input  logic                        i_dev_ZZ0,
    input  logic [dkp_pkg::WORD_W-1:0]  i_dev_sr,
    input  logic                        i_load_a,
    input  logic                        i_load_b,
    input  logic                        i_load_c,
    input  logic                        i_start,
    input  logic                        i_clear,
    input  logic [1:0]                  i_stat_sel,
    output logic [dkp_pkg::WORD_W-1:0]  o_dev_sc,
    output logic                        o_busy,
    output logic                        o_done,
    input  logic                        i_spi_miso,
    output logic                        o_spi_sck,
    output logic                        o_spi_ncs,
    output logic                        o_spi_mosi,
    input  logic                        i_credit,
    output logic                        o_word_valid,
    output logic [dkp_pkg::WORD_W-1:0]  o_word,
    output logic [dkp_pkg::MADDR_W-1:0] o_word_addr
);

    dkp_pkg::mode_e                 mode;
    logic [dkp_pkg::CYL_W-1:0]      cyl_arg;
    logic [dkp_pkg::WORD_W-1:0]     reg_b;
    logic [dkp_pkg::WORD_W-1:0]     reg_c;
    logic [dkp_pkg::SURF_W-1:0]     surf;
    logic [dkp_pkg::SECT_W-1:0]     sect;
    logic [3:0]                     count;
    logic [dkp_pkg::FLS_ADDR_W-1:0] flash_addr;
    logic [7:0]                     spi_byte;
    logic load, cyl_load, cyl_clear, spi_start, byte_sel;
    logic lo_byte, hi_byte, send, sent, word_step, sector_step;
    logic sector_end, last_sector, spi_busy, byte_valid;
    logic cmd_done, rw_done, seek_done;

    dkp_regs u_regs (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_dev_sr(i_dev_sr),
        .i_load_a(i_load_a), .i_load_b(i_load_b), .i_load_c(i_load_c),
        .i_start(i_start), .i_clear(i_clear), .i_cmd_done(cmd_done),
        .i_stat_sel(i_stat_sel), .i_rw_done(rw_done), .i_seek_done(seek_done),
        .i_maddr(o_word_addr), .i_surf(surf), .i_sect(sect), .i_count(count),
        .o_mode(mode), .o_cyl_arg(cyl_arg), .o_b(reg_b), .o_c(reg_c),
        .o_busy(o_busy), .o_done(o_done), .o_dev_sc(o_dev_sc)
    );

    dkp_geometry #(.SECTOR_WORDS(SECTOR_WORDS)) u_geometry (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_c(reg_c), .i_load(load),
        .i_cyl_load(cyl_load), .i_cyl_clear(cyl_clear), .i_cyl_arg(cyl_arg),
        .i_word_step(word_step), .i_sector_step(sector_step), .i_byte_sel(byte_sel),
        .o_flash_addr(flash_addr), .o_surf(surf), .o_sect(sect), .o_count(count),
        .o_sector_end(sector_end), .o_last_sector(last_sector)
    );

    dkp_spi_reader u_spi_reader (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_start(spi_start), .i_addr(flash_addr),
        .i_spi_miso(i_spi_miso), .o_spi_sck(o_spi_sck), .o_spi_ncs(o_spi_ncs),
        .o_spi_mosi(o_spi_mosi), .o_busy(spi_busy), .o_byte_valid(byte_valid),
        .o_byte(spi_byte)
    );

    dkp_word_out #(.CREDITS(CREDITS)) u_word_out (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_lo_byte(lo_byte), .i_hi_byte(hi_byte),
        .i_byte(spi_byte), .i_send(send), .i_b(reg_b), .i_load(load), .i_credit(i_credit),
        .o_sent(sent), .o_word_valid(o_word_valid), .o_word(o_word),
        .o_word_addr(o_word_addr)
    );

    dkp_seq u_seq (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_busy(o_busy), .i_mode(mode),
        .i_spi_busy(spi_busy), .i_byte_valid(byte_valid), .i_sector_end(sector_end),
        .i_last_sector(last_sector), .i_sent(sent), .o_load(load),
        .o_cyl_load(cyl_load), .o_cyl_clear(cyl_clear), .o_spi_start(spi_start),
        .o_byte_sel(byte_sel), .o_lo_byte(lo_byte), .o_hi_byte(hi_byte),
        .o_send(send), .o_word_step(word_step), .o_sector_step(sector_step),
        .o_cmd_done(cmd_done), .o_rw_done(rw_done), .o_seek_done(seek_done)
    );

endmodule

/* test/flash_model.sv */
// behavioral SPI flash for simulation, answers a 03h read with a byte made from its address
module flash_model (
    input  logic i_sck,
    input  logic i_ncs,
    input  logic i_mosi,
    output logic o_miso
);

    logic [31:0] shift_in;   // opcode and 24-bit address
    logic [7:0]  data_out;
    logic [7:0]  addr_byte;
    int          nbits;

    // low address byte xor the middle one, all ones for an unknown opcode
    assign addr_byte = (shift_in[31:24] == 8'h03) ? (shift_in[7:0] ^ shift_in[15:8]) : 8'hff;

    always @(posedge i_sck or posedge i_ncs) begin
        if (i_ncs) begin
            nbits <= 0;
        end else begin
            shift_in <= {shift_in[30:0], i_mosi};
            nbits    <= nbits + 1;
        end
    end

    // mode 0, data changes on falling sck
    always @(negedge i_sck or posedge i_ncs) begin
        if (i_ncs) begin
            o_miso <= 1'b0;
        end else if (nbits == 32) begin
            o_miso   <= addr_byte[7];
            data_out <= {addr_byte[6:0], 1'b0};
        end else if (nbits > 32) begin
            o_miso   <= data_out[7];
            data_out <= {data_out[6:0], 1'b0};
        end
    end

endmodule

/* test/tb_dkp.sv */
// testbench for the disk controller that runs seek, recalibrate and credit-paced reads on a flash model
module tb_dkp;

    localparam int SECTOR_WORDS = 4;
    localparam int CREDITS      = 2;
    localparam int TOTAL_WORDS  = 12;   // both reads together

    logic        i_DRA, i_dev_ZZ0, i_load_a, i_load_b, i_load_c, i_start, i_clear, i_credit;
    logic [15:0] i_dev_sr;
    logic [1:0]  i_stat_sel;
    logic [15:0] o_dev_sc, o_word;
    logic [14:0] o_word_addr;
    logic        o_busy, o_done, o_word_valid;
    logic        spi_miso, spi_sck, spi_ncs, spi_mosi;

    logic [15:0] next_a, next_b, next_c;
    logic [1:0]  cmd_mode;
    logic [7:0]  exp_cyl;
    logic [3:0]  pos_surf;
    logic [2:0]  pos_sect;
    logic [7:0]  pos_widx;
    logic [14:0] exp_addr;
    logic [15:0] exp_word;
    logic [15:0] sc_expect;
    logic        hold_credits, sc_check;
    int          exp_words, words_base, words_total, credits_back, busy_len;
    integer      seed = 32'h5eff;

    dkp_top #(.SECTOR_WORDS(SECTOR_WORDS), .CREDITS(CREDITS)) dut0 (
        .i_DRA(i_DRA), .i_dev_ZZ0(i_dev_ZZ0), .i_dev_sr(i_dev_sr), .i_load_a(i_load_a),
        .i_load_b(i_load_b), .i_load_c(i_load_c), .i_start(i_start), .i_clear(i_clear),
        .i_stat_sel(i_stat_sel), .o_dev_sc(o_dev_sc), .o_busy(o_busy), .o_done(o_done),
        .i_spi_miso(spi_miso), .o_spi_sck(spi_sck), .o_spi_ncs(spi_ncs),
        .o_spi_mosi(spi_mosi), .i_credit(i_credit), .o_word_valid(o_word_valid),
        .o_word(o_word), .o_word_addr(o_word_addr)
    );

    flash_model flash0 (.i_sck(spi_sck), .i_ncs(spi_ncs), .i_mosi(spi_mosi), .o_miso(spi_miso));

    function automatic logic [15:0] flash_word(input logic [7:0] cyl, input logic [3:0] surf,
                                               input logic [2:0] sect, input logic [7:0] widx);
        logic [5:0]  sursec;
        logic [23:0] lo_a;
        logic [23:0] hi_a;
        sursec = {2'b00, surf} * 6'd6 + {3'b000, sect};
        lo_a   = {1'b0, cyl, sursec, widx, 1'b0};
        hi_a   = lo_a | 24'd1;   // odd byte goes to the upper half
        return {hi_a[7:0] ^ hi_a[15:8], lo_a[7:0] ^ lo_a[15:8]};
    endfunction

    assign exp_word = flash_word(exp_cyl, pos_surf, pos_sect, pos_widx);

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_with($sformatf("Mismatch at time %0t: %s expected %0h actual %0h",
                            $time, sig, expected, actual));
    endtask

    task automatic load_reg(input logic [1:0] sel, input logic [15:0] val);
        @(posedge i_DRA);
        i_dev_sr <= val;
        i_load_a <= (sel == 2'd0);
        i_load_b <= (sel == 2'd1);
        i_load_c <= (sel == 2'd2);
        @(posedge i_DRA);
        i_load_a <= 1'b0;
        i_load_b <= 1'b0;
        i_load_c <= 1'b0;
    endtask

    task automatic issue_command(input logic [15:0] a, input logic [15:0] b,
                                 input logic [15:0] c);
        next_a <= a;
        next_b <= b;
        next_c <= c;
        load_reg(2'd0, a);
        load_reg(2'd1, b);
        load_reg(2'd2, c);
        @(posedge i_DRA);
        i_start <= 1'b1;
        @(posedge i_DRA);
        i_start <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge i_DRA); while (!o_done);
    endtask

    task automatic check_status(input logic [1:0] sel, input logic [15:0] expected);
        @(posedge i_DRA);
        i_stat_sel <= sel;
        sc_expect  <= expected;
        sc_check   <= 1'b1;
        @(posedge i_DRA);
        sc_check   <= 1'b0;
    endtask

    always #50 i_DRA = ~i_DRA;

    // reference position tracking each command and each word that leaves
    always @(posedge i_DRA) begin
        busy_len <= o_busy ? busy_len + 1 : 0;
        if (i_credit)
            credits_back <= credits_back + 1;
        if (i_start) begin
            cmd_mode   <= next_a[9:8];
            pos_surf   <= next_c[11:8];
            pos_sect   <= next_c[6:4];
            pos_widx   <= 8'd0;
            exp_addr   <= next_b[14:0];
            exp_words  <= (16 - int'(next_c[3:0])) * SECTOR_WORDS;
            words_base <= words_total;
            if (next_a[9:8] == dkp_pkg::MODE_SEEK)
                exp_cyl <= next_a[7:0];
            else if (next_a[9:8] == dkp_pkg::MODE_RECAL)
                exp_cyl <= 8'd0;
        end
        if (o_word_valid) begin
            words_total <= words_total + 1;
            exp_addr    <= exp_addr + 15'd1;
            if (pos_widx == 8'(SECTOR_WORDS - 1)) begin
                pos_widx <= 8'd0;
                if (pos_sect == 3'd5) begin   // last sector of the surface
                    pos_sect <= 3'd0;
                    pos_surf <= pos_surf + 4'd1;
                end else begin
                    pos_sect <= pos_sect + 3'd1;
                end
            end else begin
                pos_widx <= pos_widx + 8'd1;
            end
        end
    end

    a_reset_state: assert property (@(posedge i_DRA)
        $fell(i_dev_ZZ0) |-> !o_busy && !o_done && !o_word_valid && spi_ncs)
        else stop_with("outputs not idle after reset");

    a_short_cmd: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        $rose(o_done) && cmd_mode[1] |-> busy_len == 2)
        else report_mismatch("busy cycles", 32'd2, $sampled(busy_len));

    a_word: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        o_word_valid |-> o_word == exp_word)
        else report_mismatch("o_word", 32'($sampled(exp_word)), 32'($sampled(o_word)));

    a_word_addr: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        o_word_valid |-> o_word_addr == exp_addr)
        else report_mismatch("o_word_addr", 32'($sampled(exp_addr)),
                             32'($sampled(o_word_addr)));

    a_credit_bound: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        o_word_valid |-> words_total < CREDITS + credits_back)
        else stop_with("word sent with no credit left");

    a_held_stall: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        $fell(hold_credits) |-> words_total == CREDITS)
        else report_mismatch("words while credits held", CREDITS, $sampled(words_total));

    a_read_len: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        $rose(o_done) && cmd_mode == dkp_pkg::MODE_READ |-> words_total - words_base == exp_words)
        else report_mismatch("words per read", $sampled(exp_words),
                             $sampled(words_total - words_base));

    a_status: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        sc_check |-> o_dev_sc == sc_expect)
        else report_mismatch("o_dev_sc", 32'($sampled(sc_expect)), 32'($sampled(o_dev_sc)));

    a_clear: assert property (@(posedge i_DRA) disable iff (i_dev_ZZ0)
        $past(i_clear) |-> !o_done)
        else report_mismatch("o_done", 32'd0, 32'($sampled(o_done)));

    // host side returns one credit per word after a random gap
    initial begin : credit_return
        int gap;
        forever begin
            @(posedge i_DRA);
            if (!hold_credits && words_total > credits_back) begin
                gap = $random(seed) & 32'h7;
                repeat (gap) @(posedge i_DRA);
                i_credit <= 1'b1;
                @(posedge i_DRA);
                i_credit <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TOTAL_WORDS * 200 + 3000) @(posedge i_DRA);
        stop_with("timeout, the test did not finish in time");
    end

    initial begin
        i_DRA        = 1'b0;
        i_dev_ZZ0    = 1'b1;
        i_dev_sr     = 16'd0;
        i_load_a     = 1'b0;
        i_load_b     = 1'b0;
        i_load_c     = 1'b0;
        i_start      = 1'b0;
        i_clear      = 1'b0;
        i_credit     = 1'b0;
        i_stat_sel   = 2'd0;
        hold_credits = 1'b0;
        sc_check     = 1'b0;
        sc_expect    = 16'd0;
        repeat (8) @(posedge i_DRA);
        i_dev_ZZ0 <= 1'b0;
        repeat (3) @(posedge i_DRA);

        issue_command(16'h025b, 16'h0000, 16'h0000);   // seek cylinder 5b, odd so it shows in the data
        wait_done();
        check_status(2'd0, 16'h4000);

        // two sectors from surface 2 sector 5 with credits withheld at first
        hold_credits <= 1'b1;
        issue_command(16'h0000, 16'h1234, 16'h025e);
        repeat (800) @(posedge i_DRA);
        hold_credits <= 1'b0;
        wait_done();
        check_status(2'd2, 16'h0310);
        check_status(2'd0, 16'hc000);
        check_status(2'd1, 16'h123c);
        @(posedge i_DRA);
        i_clear <= 1'b1;
        @(posedge i_DRA);
        i_clear <= 1'b0;

        issue_command(16'h0300, 16'h0000, 16'h0000);   // recalibrate
        wait_done();
        issue_command(16'h0000, 16'h0100, 16'h002f);   // one sector on cylinder 0
        wait_done();
        check_status(2'd1, 16'h0104);
        repeat (4) @(posedge i_DRA);
        $display("Regression passed");
        $finish;
    end

endmodule

/* sim.f */
logic/dkp_pkg.sv
logic/dkp_regs.sv
logic/dkp_geometry.sv
logic/dkp_spi_reader.sv
logic/dkp_word_out.sv
logic/dkp_seq.sv
logic/dkp_top.sv
test/flash_model.sv
test/tb_dkp.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --top-module tb_dkp -f sim.f -o tb_dkp &&
    ./obj_dir/tb_dkp | tee /dev/stderr | grep -qx "Regression passed" &&
    echo "simulation ok" || { echo "simulation FAILED"; exit 1; }
